//--- common/conv_pkg.sv
package conv_pkg;

	localparam int PIX_W   = 8;                 // Pixel and weight width
	localparam int ROW_PIX = 8;                 // Pixels per row
	localparam int K       = 3;                 // Kernel side
	localparam int N_POS   = ROW_PIX - K + 1;   // Window positions per row
	localparam int PROD_W  = 16;
	localparam int SUM_W   = 20;                // Nine 16-bit products fit

	// Kind bit of a load word
	localparam logic KIND_PIX = 1'b0;
	localparam logic KIND_WGT = 1'b1;

	typedef logic [PIX_W-1:0] pix_t;

	typedef pix_t [ROW_PIX-1:0] row_t;          // Pixel 0 in the low byte

	// One bus word, either a pixel row or a weight beat
	typedef union packed {
		row_t               pixels;
		pix_t [ROW_PIX-1:0] weights;            // Weight 0 in the low byte
	} load_word_u;

	typedef struct packed {
		logic       kind;
		load_word_u word;
	} load_t;

	// Weight index is K*r + c, r counted from the oldest row
	typedef pix_t [K*K-1:0] kernel_t;

	typedef struct packed {
		row_t [K-1:0] rows;                     // rows[0] is the oldest
		kernel_t      kernel;
	} window_t;

	typedef struct packed {
		logic [N_POS-1:0][SUM_W-1:0] sum;       // sum[p] for position p
	} result_t;

endpackage

//--- mac_array/dot9.sv
`timescale 1ns/1ps

module dot9
	import conv_pkg::*;
(
	input  logic [K-1:0][K-1:0][PIX_W-1:0] i_win,   // [row][col], row 0 oldest
	input  kernel_t                        i_kernel,
	output logic [SUM_W-1:0]               o_sum
);

	logic [K*K-1:0][PROD_W-1:0] prod;
	logic [K-1:0][SUM_W-1:0]    row_sum;

	always_comb begin
		for (int r = 0; r < K; r++) begin
			for (int c = 0; c < K; c++) begin
				prod[K*r + c] = i_win[r][c] * i_kernel[K*r + c];
			end
		end
	end

	// Three row sums, then the total
	always_comb begin
		o_sum = '0;
		for (int r = 0; r < K; r++) begin
			row_sum[r] = SUM_W'(prod[K*r]) + SUM_W'(prod[K*r + 1]) + SUM_W'(prod[K*r + 2]);
			o_sum      = o_sum + row_sum[r];
		end
	end

endmodule

//--- mac_array/mac_array.sv
`timescale 1ns/1ps

module mac_array
	import conv_pkg::*;
#(
	parameter int OUT_CREDITS = 2
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_not_empty,
	input  window_t i_head,
	output logic    o_pop,
	output logic    o_credit,
	output logic    o_res_valid,
	output result_t o_res,
	input  logic    i_res_credit
);

	localparam int CW = $clog2(OUT_CREDITS + 1);

	logic [CW-1:0]               out_cnt;
	logic [N_POS-1:0][SUM_W-1:0] sums;

	// An item only leaves the FIFO when its result can be sent
	assign o_pop    = i_not_empty && (out_cnt != '0);
	assign o_credit = o_pop;   // Freed FIFO slot

	for (genvar p = 0; p < N_POS; p++) begin : g_pos
		logic [K-1:0][K-1:0][PIX_W-1:0] win;

		always_comb begin
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K; c++) begin
					win[r][c] = i_head.rows[r][p + c];
				end
			end
		end

		dot9 u_dot (
			.i_win(win),
			.i_kernel(i_head.kernel),
			.o_sum(sums[p])
		);
	end

	always_ff @(posedge clk) begin
		if (o_pop) begin
			o_res.sum <= sums;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_res_valid <= 1'b0;
			out_cnt     <= CW'(OUT_CREDITS);
		end else begin
			o_res_valid <= o_pop;
			out_cnt     <= out_cnt - CW'(o_pop) + CW'(i_res_credit);
		end
	end

endmodule

//--- rtl/conv3x3_core.sv
`timescale 1ns/1ps

module conv3x3_core
	import conv_pkg::*;
#(
	parameter int FIFO_DEPTH  = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_load_valid,
	input  load_t   i_load,
	output logic    o_load_ready,
	output logic    o_res_valid,
	output result_t o_res,
	input  logic    i_res_credit
);

	logic    push;
	window_t item;
	logic    not_empty;
	window_t head;
	logic    pop;
	logic    fifo_credit;

	row_window #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_row (
		.clk(clk),
		.rst(rst),
		.i_load_valid(i_load_valid),
		.i_load(i_load),
		.o_load_ready(o_load_ready),
		.o_push(push),
		.o_item(item),
		.i_credit(fifo_credit)
	);

	window_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.i_push(push),
		.i_item(item),
		.o_not_empty(not_empty),
		.o_head(head),
		.i_pop(pop)
	);

	mac_array #(
		.OUT_CREDITS(OUT_CREDITS)
	) u_mac (
		.clk(clk),
		.rst(rst),
		.i_not_empty(not_empty),
		.i_head(head),
		.o_pop(pop),
		.o_credit(fifo_credit),   // Back to the producer
		.o_res_valid(o_res_valid),
		.o_res(o_res),
		.i_res_credit(i_res_credit)
	);

endmodule

//--- rtl/row_window.sv
`timescale 1ns/1ps

module row_window
	import conv_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_load_valid,
	input  load_t   i_load,
	output logic    o_load_ready,
	output logic    o_push,
	output window_t o_item,
	input  logic    i_credit
);

	localparam int CW = $clog2(FIFO_DEPTH + 1);

	row_t [K-1:0]       row_q;        // Shifting rows, [0] oldest
	kernel_t            kernel_q;
	pix_t [ROW_PIX-1:0] beat_lo;      // First weight beat waits here
	logic               beat_odd;     // First beat taken, second expected
	logic [1:0]         rows_held;    // Saturates at K-1
	logic [CW-1:0]      credit_cnt;
	logic               accept;
	logic               take_row;
	logic               take_wgt;
	logic               completes;

	assign accept    = i_load_valid && o_load_ready;
	assign take_row  = accept && (i_load.kind == KIND_PIX);
	assign take_wgt  = accept && (i_load.kind == KIND_WGT);
	assign completes = take_row && (rows_held == 2'(K - 1));

	// No word is taken that the FIFO could not hold
	assign o_load_ready = (credit_cnt != '0);

	// Rows and kernel only change on a later accept, so the item is stable while o_push is high
	assign o_item = '{rows: row_q, kernel: kernel_q};

	always_ff @(posedge clk) begin
		if (take_row) begin
			row_q <= {i_load.word.pixels, row_q[K-1:1]};
		end
		if (take_wgt) begin
			if (beat_odd) begin
				kernel_q <= {i_load.word.weights[0], beat_lo};   // Weight 8 on top
			end else begin
				beat_lo <= i_load.word.weights;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_odd   <= 1'b0;
			rows_held  <= '0;
			credit_cnt <= CW'(FIFO_DEPTH);
			o_push     <= 1'b0;
		end else begin
			o_push <= completes;
			// Credit is taken when the push is scheduled
			credit_cnt <= credit_cnt - CW'(completes) + CW'(i_credit);
			if (take_wgt) begin
				beat_odd <= !beat_odd;
				if (beat_odd) begin
					rows_held <= '0;   // New kernel, new pass
				end
			end else if (take_row && rows_held != 2'(K - 1)) begin
				rows_held <= rows_held + 2'd1;
			end
		end
	end

endmodule

//--- rtl/window_fifo.sv
`timescale 1ns/1ps

module window_fifo
	import conv_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_push,
	input  window_t i_item,
	output logic    o_not_empty,
	output window_t o_head,
	input  logic    i_pop
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	window_t       mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          do_push;
	logic          do_pop;

	assign full        = (count == CW'(FIFO_DEPTH));
	assign o_not_empty = (count != '0);
	assign o_head      = mem[rd_ptr];
	assign do_push     = i_push && !full;
	assign do_pop      = i_pop && o_not_empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_item;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
			end
			count <= count + CW'(do_push) - CW'(do_pop);
		end
	end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module conv_tb \
	-f verilog.f -o conv_tb_sim
out=$(./obj_dir/conv_tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF "All tests passed!"; then
	exit 0
fi
exit 1

//--- test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 10
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = !o_clk;
	end

	initial begin
		o_rst = 1'b0;   // Active low, held from time zero
		repeat (RST_CYCLES) @(posedge o_clk);
		#1 o_rst = 1'b1;
	end

endmodule

//--- test/conv_properties.sv
`timescale 1ns/1ps

module conv_properties #(
	parameter int OUT_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic i_push,
	input logic i_fifo_full,
	input logic i_res_valid,
	input logic i_res_credit
);

	int push_fails;
	int credit_fails;
	int reset_fails;
	int credit_avail;   // Credits handed out, minus results seen

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			credit_avail <= OUT_CREDITS;
		end else begin
			credit_avail <= credit_avail - int'(i_res_valid) + int'(i_res_credit);
		end
	end

	// Producer may only push into a free slot
	assert property (@(posedge clk) disable iff (!rst) i_push |-> !i_fifo_full)
	else begin
		$error("window FIFO pushed while full");
		push_fails++;
	end

	// Each result spends a credit that was already free
	assert property (@(posedge clk) disable iff (!rst) i_res_valid |-> (credit_avail > 0))
	else begin
		$error("o_res_valid rose with zero output credit");
		credit_fails++;
	end

	assert property (@(posedge clk) !rst |-> !i_res_valid)
	else begin
		$error("o_res_valid high during reset");
		reset_fails++;
	end

endmodule

//--- test/conv_tb.sv
`timescale 1ns/1ps

module conv_tb
	import conv_pkg::*;
();

	localparam int FIFO_DEPTH  = 4;
	localparam int OUT_CREDITS = 2;

	logic             clk;
	logic             rst;
	logic             load_valid;
	load_t            load;
	logic             load_ready;
	logic             res_valid;
	result_t          res;
	logic             res_credit;
	int               seed = 62;
	result_t          exp_q[$];    // Expected results in order
	logic [63:0]      m_row [K];   // Model rows, [0] oldest
	logic [63:0]      m_lo;        // First weight beat
	logic [PIX_W-1:0] m_w [K*K];
	bit               m_odd;
	int               m_held;
	int               m_items;
	bit               auto_credit;
	int               n_res;
	int               n_cred;
	int               mon_errs;
	int               errs;
	int               n_pass;
	int               n_fail;

	clk_gen u_clk (
		.o_clk(clk),
		.o_rst(rst)
	);

	conv3x3_core #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.i_load_valid(load_valid),
		.i_load(load),
		.o_load_ready(load_ready),
		.o_res_valid(res_valid),
		.o_res(res),
		.i_res_credit(res_credit)
	);

	bind conv3x3_core conv_properties #(.OUT_CREDITS(OUT_CREDITS)) u_props (
		.clk(clk),
		.rst(rst),
		.i_push(push),
		.i_fifo_full(u_fifo.full),
		.i_res_valid(o_res_valid),
		.i_res_credit(i_res_credit)
	);

	function automatic int errs_total();
		return errs + mon_errs + u_dut.u_props.push_fails + u_dut.u_props.credit_fails
			+ u_dut.u_props.reset_fails;
	endfunction

	function automatic logic [63:0] rand_word();
		logic [63:0] w;
		for (int i = 0; i < 8; i++) begin
			w[8*i +: 8] = 8'($random(seed));
		end
		return w;
	endfunction

	// Six 3x3 dot products over the three held rows
	function automatic result_t expected_result();
		result_t e;
		int      acc;
		for (int p = 0; p < N_POS; p++) begin
			acc = 0;
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K; c++) begin
					acc += int'(m_row[r][8*(p + c) +: 8]) * int'(m_w[K*r + c]);
				end
			end
			e.sum[p] = SUM_W'(acc);
		end
		return e;
	endfunction

	function automatic void model_accept(input logic kind, input logic [63:0] data);
		if (kind == KIND_WGT) begin
			if (m_odd) begin
				for (int i = 0; i < 8; i++) begin
					m_w[i] = m_lo[8*i +: 8];
				end
				m_w[8] = data[7:0];   // Weight 8 in the low byte
				m_held = 0;
			end else begin
				m_lo = data;
			end
			m_odd = !m_odd;
		end else begin
			m_row[0] = m_row[1];
			m_row[1] = m_row[2];
			m_row[2] = data;
			if (m_held < K - 1) begin
				m_held++;
			end else begin
				exp_q.push_back(expected_result());
				m_items++;
			end
		end
	endfunction

	// Called 1 ns after a rising edge, returns at the same phase
	task automatic send_word(input logic kind, input logic [63:0] data, input int max_wait,
			output bit ok);
		int waited;
		ok = 1'b0;
		waited = 0;
		load_valid = 1'b1;
		load.kind = kind;
		load.word.pixels = data;
		while (!load_ready && waited < max_wait) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (load_ready) begin
			@(posedge clk);
			#1;
			ok = 1'b1;
		end
		load_valid = 1'b0;
		if (ok) begin
			model_accept(kind, data);
		end
	endtask

	task automatic send(input logic kind, input logic [63:0] data);
		bit ok;
		send_word(kind, data, 40, ok);
		assert (ok) else begin
			$display("load word was not accepted before the timeout");
			errs++;
		end
	endtask

	task automatic send_kernel();
		send(KIND_WGT, rand_word());
		send(KIND_WGT, rand_word());   // Upper bytes are ignored
	endtask

	task automatic send_rows(input int n);
		for (int i = 0; i < n; i++) begin
			send(KIND_PIX, rand_word());
		end
	endtask

	// All expected results seen and all credits handed back
	task automatic wait_idle();
		int t;
		t = 0;
		while ((exp_q.size() != 0 || n_cred != n_res) && t < 300) begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (exp_q.size() == 0 && n_cred == n_res) else begin
			$display("results still missing after the timeout");
			errs++;
		end
	endtask

	task automatic check_count(input int got, input int want);
		assert (got == want) else begin
			$display("error: o_res_valid pulses = %h, expected %h", got, want);
			errs++;
		end
	endtask

	task automatic end_test(input int num, input string name, input int base);
		if (errs_total() == base) begin
			n_pass++;
			$display("test %0d %s: pass", num, name);
		end else begin
			n_fail++;
			$display("test %0d %s: FAIL", num, name);
		end
	endtask

	always @(negedge clk) begin
		result_t e;
		if (rst && res_valid) begin
			n_res++;
			assert (exp_q.size() != 0) else begin
				$display("unexpected result on o_res with no window item pending");
				mon_errs++;
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				assert (res == e) else begin
					$display("error: o_res = %h, expected %h", res, e);
					mon_errs++;
				end
			end
		end
	end

	// One credit pulse back per result seen
	initial begin
		res_credit = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (auto_credit && n_cred < n_res) begin
				res_credit = 1'b1;
				n_cred++;
			end else begin
				res_credit = 1'b0;
			end
		end
	end

	initial begin
		int base;
		int items0;
		int m0;
		int t;
		int rows;
		bit ok;
		load_valid = 1'b0;
		load = '0;
		t = 0;
		while (!rst && t < 50) begin
			@(posedge clk);
			t++;
		end
		#1;
		assert (rst) else begin
			$display("reset was never released");
			errs++;
		end

		base = errs_total();
		assert (!res_valid) else begin
			$display("error: o_res_valid = %h, expected 0", res_valid);
			errs++;
		end
		assert (load_ready) else begin
			$display("error: o_load_ready = %h, expected 1", load_ready);
			errs++;
		end
		end_test(1, "reset state", base);

		base = errs_total();
		items0 = n_res;
		auto_credit = 1'b1;
		send_kernel();
		send_rows(3);
		wait_idle();
		check_count(n_res - items0, 1);
		end_test(2, "single window", base);

		base = errs_total();
		items0 = n_res;
		send_kernel();
		send_rows(12);
		wait_idle();
		check_count(n_res - items0, 10);
		end_test(3, "random stream", base);

		base = errs_total();
		items0 = n_res;
		m0 = m_items;
		auto_credit = 1'b0;
		send_kernel();
		ok = 1'b1;
		rows = 0;
		while (ok && rows < 20) begin
			send_word(KIND_PIX, rand_word(), 8, ok);
			rows++;
		end
		assert (!ok && !load_ready) else begin
			$display("o_load_ready never fell while output credits were withheld");
			errs++;
		end
		check_count(n_res - items0, OUT_CREDITS);
		auto_credit = 1'b1;
		wait_idle();
		check_count(n_res - items0, m_items - m0);
		end_test(4, "credit back-pressure", base);

		base = errs_total();
		items0 = n_res;
		m0 = m_items;
		auto_credit = 1'b0;
		send_kernel();
		send_rows(6);   // Two items stay queued behind the credits
		send_kernel();
		send_rows(3);
		check_count(n_res - items0, OUT_CREDITS);
		auto_credit = 1'b1;
		wait_idle();
		check_count(n_res - items0, m_items - m0);
		end_test(5, "kernel reload in flight", base);

		repeat (10) @(posedge clk);   // Catch stray results
		base = errs_total();
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			n_pass + n_fail, n_pass, n_fail, base);
		if (n_fail == 0 && base == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- verilog.f
common/conv_pkg.sv
mac_array/dot9.sv
mac_array/mac_array.sv
rtl/window_fifo.sv
rtl/row_window.sv
rtl/conv3x3_core.sv
test/clk_gen.sv
test/conv_properties.sv
test/conv_tb.sv
